// ==== common/render_pkg.sv ====
// screen-side types for the play-field renderer: coordinates, colours, sprite codes
`default_nettype none

package render_pkg;

    typedef logic [9:0] coord_t;   // h or v counter value
    typedef logic [11:0] color_t;  // 4 bits each of r, g, b
    typedef logic [1:0] code_t;    // colour code as stored in sprite memory

    localparam code_t CODE_WHITE = 2'd0;
    localparam code_t CODE_BLACK = 2'd1;
    localparam code_t CODE_RED = 2'd2;
    localparam code_t CODE_CLEAR = 2'd3;  // transparent

endpackage

`default_nettype wire

// ==== common/render_settings.svh ====
// render settings: slot count, screen bands, palette, sprite geometry and memory size
`ifndef RENDER_SETTINGS_SVH
`define RENDER_SETTINGS_SVH

`define RENDER_SLOTS 8

// background bands, row numbers
`define SKY_END 10'd140
`define PATH_TOP 10'd170
`define PATH_END 10'd230
`define BOARD_TOP 10'd270

// 12-bit rgb palette
`define COLOR_SKY 12'h2bf
`define COLOR_GRASS 12'h5b2
`define COLOR_PATH 12'hda5
`define COLOR_BOARD 12'hfb7
`define COLOR_WHITE 12'hfff
`define COLOR_RED 12'hf00
`define COLOR_BLACK 12'h000

`define SPRITE_MEM_DEPTH 2048
`define SPRITE_FRAMES 4

// sprite size in memory pixels, drawn at twice this on screen
`define SPRITE_W0 5'd8
`define SPRITE_H0 5'd8
`define SPRITE_W1 5'd12
`define SPRITE_H1 5'd8
`define SPRITE_W2 5'd8
`define SPRITE_H2 5'd12
`define SPRITE_W3 5'd16
`define SPRITE_H3 5'd16

// first frame of each kind, frames follow back to back
`define KIND_BASE0 11'd0
`define KIND_BASE1 11'd256
`define KIND_BASE2 11'd640
`define KIND_BASE3 11'd1024

`endif

// ==== common/unit_pkg.sv ====
// unit record layout, record field types and animation states
`default_nettype none

package unit_pkg;

    // 55 exist | 54:52 kind | 51:42 x | 41:32 y | 31:20 hp | 19:16 state
    // 15:12 state count | 11:0 damage
    typedef logic [55:0] unit_rec_t;

    typedef logic [2:0] kind_t;
    typedef logic [4:0] sprite_dim_t;
    typedef logic [10:0] sprite_addr_t;

    typedef enum logic [3:0] {
        ANIM_IDLE = 4'd0,
        ANIM_WALK = 4'd1,
        ANIM_ATTACK = 4'd2,
        ANIM_HIT = 4'd3
    } anim_state_t;

    function automatic logic rec_exist(unit_rec_t r);
        return r[55];
    endfunction

    function automatic kind_t rec_kind(unit_rec_t r);
        return r[54:52];
    endfunction

    function automatic render_pkg::coord_t rec_x(unit_rec_t r);
        return r[51:42];
    endfunction

    function automatic render_pkg::coord_t rec_y(unit_rec_t r);
        return r[41:32];
    endfunction

    function automatic anim_state_t rec_state(unit_rec_t r);
        return anim_state_t'(r[19:16]);  // codes above 3 fall to default frame
    endfunction

endpackage

`default_nettype wire

// ==== filelist.f ====
+incdir+common
common/render_pkg.sv
common/unit_pkg.sv
sprite/unit_decoder.sv
sprite/sprite_lookup.sv
src/pixel_compositor.sv
src/play_render.sv
test/play_render_properties.sv
test/play_render_tb.sv

// ==== sprite/sprite_lookup.sv ====
// sprite lookup: bounding-box test and 2x-scaled sprite memory read for one slot
`timescale 1ns/1ns
`default_nettype none

`include "render_settings.svh"

module sprite_lookup (
    input  logic clk_25MHz,
    input  logic rst,
    input  render_pkg::coord_t px_h,
    input  render_pkg::coord_t px_v,
    input  logic slot_en,
    input  render_pkg::coord_t slot_x,
    input  render_pkg::coord_t slot_y,
    input  unit_pkg::sprite_dim_t slot_w,
    input  unit_pkg::sprite_dim_t slot_h,
    input  unit_pkg::sprite_addr_t slot_base,
    input  logic mem_we,
    input  unit_pkg::sprite_addr_t mem_waddr,
    input  render_pkg::code_t mem_wdata,
    output logic slot_hit,
    output render_pkg::code_t slot_code
);
    import render_pkg::*;
    import unit_pkg::*;

    code_t mem [`SPRITE_MEM_DEPTH];

    coord_t dx;
    coord_t dy;
    logic in_x;
    logic in_y;
    logic hit;
    sprite_addr_t rd_addr;

    // offsets from the sprite origin, only meaningful inside the box
    assign dx = px_h - slot_x;
    assign dy = px_v - slot_y;

    // screen box is twice the memory size
    assign in_x = (px_h >= slot_x) && (dx < {slot_w, 1'b0});
    assign in_y = (px_v >= slot_y) && (dy < {slot_h, 1'b0});
    assign hit = slot_en && in_x && in_y;

    assign rd_addr = slot_base
        + sprite_addr_t'(dy >> 1) * sprite_addr_t'(slot_w)
        + sprite_addr_t'(dx >> 1);

    always_ff @(posedge clk_25MHz) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    // read sees the old word on a same-cycle write
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            slot_hit <= 1'b0;
            slot_code <= CODE_CLEAR;
        end else begin
            slot_hit <= hit;
            slot_code <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== sprite/unit_decoder.sv ====
// unit decoder: turns each unit record into a registered slot description
`timescale 1ns/1ns
`default_nettype none

`include "render_settings.svh"

module unit_decoder (
    input  logic clk_25MHz,
    input  logic rst,
    input  render_pkg::coord_t h_cnt,
    input  render_pkg::coord_t v_cnt,
    input  unit_pkg::unit_rec_t [`RENDER_SLOTS-1:0] unit_table,
    output logic [`RENDER_SLOTS-1:0] slot_en,
    output render_pkg::coord_t [`RENDER_SLOTS-1:0] slot_x,
    output render_pkg::coord_t [`RENDER_SLOTS-1:0] slot_y,
    output unit_pkg::sprite_dim_t [`RENDER_SLOTS-1:0] slot_w,
    output unit_pkg::sprite_dim_t [`RENDER_SLOTS-1:0] slot_h,
    output unit_pkg::sprite_addr_t [`RENDER_SLOTS-1:0] slot_base,
    output render_pkg::coord_t px_h,
    output render_pkg::coord_t px_v
);
    import render_pkg::*;
    import unit_pkg::*;

    logic [`RENDER_SLOTS-1:0] en_d;
    sprite_dim_t [`RENDER_SLOTS-1:0] w_d;
    sprite_dim_t [`RENDER_SLOTS-1:0] h_d;
    sprite_addr_t [`RENDER_SLOTS-1:0] base_d;

    always_comb begin
        unit_rec_t rec;
        coord_t x;
        logic kind_ok;
        sprite_dim_t w;
        sprite_dim_t h;
        sprite_addr_t kind_base;
        logic [$clog2(`SPRITE_FRAMES)-1:0] frame;

        for (int i = 0; i < `RENDER_SLOTS; i++) begin
            rec = unit_table[i];
            x = rec_x(rec);

            kind_ok = 1'b1;
            case (rec_kind(rec))
                3'd0: begin
                    w = `SPRITE_W0;
                    h = `SPRITE_H0;
                    kind_base = `KIND_BASE0;
                end
                3'd1: begin
                    w = `SPRITE_W1;
                    h = `SPRITE_H1;
                    kind_base = `KIND_BASE1;
                end
                3'd2: begin
                    w = `SPRITE_W2;
                    h = `SPRITE_H2;
                    kind_base = `KIND_BASE2;
                end
                3'd3: begin
                    w = `SPRITE_W3;
                    h = `SPRITE_H3;
                    kind_base = `KIND_BASE3;
                end
                default: begin  // no sprite for kinds 4..7
                    kind_ok = 1'b0;
                    w = '0;
                    h = '0;
                    kind_base = '0;
                end
            endcase

            case (rec_state(rec))
                ANIM_WALK: frame = x[3] ? 2'd1 : 2'd0;  // step every 8 px
                ANIM_ATTACK: frame = 2'd2;
                ANIM_HIT: frame = 2'd3;
                default: frame = 2'd0;
            endcase

            en_d[i] = rec_exist(rec) && kind_ok;
            w_d[i] = w;
            h_d[i] = h;
            base_d[i] = kind_base
                + sprite_addr_t'(frame) * sprite_addr_t'(w) * sprite_addr_t'(h);
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            slot_en <= '0;
            slot_x <= '0;
            slot_y <= '0;
            slot_w <= '0;
            slot_h <= '0;
            slot_base <= '0;
            px_h <= '0;
            px_v <= '0;
        end else begin
            slot_en <= en_d;
            for (int i = 0; i < `RENDER_SLOTS; i++) begin
                slot_x[i] <= rec_x(unit_table[i]);
                slot_y[i] <= rec_y(unit_table[i]);
            end
            slot_w <= w_d;
            slot_h <= h_d;
            slot_base <= base_d;
            px_h <= h_cnt;  // coordinate travels with its slot data
            px_v <= v_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== src/pixel_compositor.sv ====
// pixel compositor: lays the winning sprite code over the banded background
`timescale 1ns/1ns
`default_nettype none

`include "render_settings.svh"

module pixel_compositor (
    input  logic clk_25MHz,
    input  logic rst,
    input  render_pkg::coord_t px_v,
    input  logic [`RENDER_SLOTS-1:0] slot_hit,
    input  render_pkg::code_t [`RENDER_SLOTS-1:0] slot_code,
    output render_pkg::color_t pixel
);
    import render_pkg::*;

    coord_t v_q;       // row of the codes now at the inputs
    logic [1:0] fill;  // pipeline fill after reset
    color_t bg;
    color_t next_pixel;

    function automatic color_t code_color(code_t code);
        case (code)
            CODE_WHITE: return `COLOR_WHITE;
            CODE_RED: return `COLOR_RED;
            default: return `COLOR_BLACK;
        endcase
    endfunction

    always_comb begin
        if (v_q >= `BOARD_TOP) begin
            bg = `COLOR_BOARD;
        end else if (v_q >= `PATH_TOP && v_q < `PATH_END) begin
            bg = `COLOR_PATH;
        end else if (v_q >= `SKY_END) begin
            bg = `COLOR_GRASS;
        end else begin
            bg = `COLOR_SKY;
        end
    end

    always_comb begin
        logic found;
        code_t win;

        found = 1'b0;
        win = CODE_CLEAR;
        // walk down so the lowest visible slot is the last one taken
        for (int i = `RENDER_SLOTS - 1; i >= 0; i--) begin
            if (slot_hit[i] && slot_code[i] != CODE_CLEAR) begin
                found = 1'b1;
                win = slot_code[i];
            end
        end

        if (found && v_q < `BOARD_TOP) begin
            next_pixel = code_color(win);
        end else begin
            next_pixel = bg;  // board rows never carry units
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            v_q <= '0;
            fill <= '0;
            pixel <= '0;
        end else begin
            v_q <= px_v;
            fill <= {fill[0], 1'b1};
            pixel <= fill[1] ? next_pixel : '0;
        end
    end

endmodule

`default_nettype wire

// ==== src/play_render.sv ====
// play-field sprite layer: decodes the unit table, looks up sprites, composes the pixel
`timescale 1ns/1ns
`default_nettype none

`include "render_settings.svh"

module play_render (
    input  logic clk_25MHz,
    input  logic rst,
    input  render_pkg::coord_t h_cnt,
    input  render_pkg::coord_t v_cnt,
    input  unit_pkg::unit_rec_t [`RENDER_SLOTS-1:0] unit_table,
    input  logic mem_we,
    input  unit_pkg::sprite_addr_t mem_waddr,
    input  render_pkg::code_t mem_wdata,
    output render_pkg::color_t pixel
);
    import render_pkg::*;
    import unit_pkg::*;

    logic [`RENDER_SLOTS-1:0] slot_en;
    coord_t [`RENDER_SLOTS-1:0] slot_x;
    coord_t [`RENDER_SLOTS-1:0] slot_y;
    sprite_dim_t [`RENDER_SLOTS-1:0] slot_w;
    sprite_dim_t [`RENDER_SLOTS-1:0] slot_h;
    sprite_addr_t [`RENDER_SLOTS-1:0] slot_base;
    coord_t px_h;
    coord_t px_v;

    logic [`RENDER_SLOTS-1:0] slot_hit;
    code_t [`RENDER_SLOTS-1:0] slot_code;

    unit_decoder u_decoder (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .h_cnt     (h_cnt),
        .v_cnt     (v_cnt),
        .unit_table(unit_table),
        .slot_en   (slot_en),
        .slot_x    (slot_x),
        .slot_y    (slot_y),
        .slot_w    (slot_w),
        .slot_h    (slot_h),
        .slot_base (slot_base),
        .px_h      (px_h),
        .px_v      (px_v)
    );

    // one lookup and one memory copy per slot, writes go to all copies
    for (genvar i = 0; i < `RENDER_SLOTS; i++) begin : g_slot
        sprite_lookup u_lookup (
            .clk_25MHz(clk_25MHz),
            .rst      (rst),
            .px_h     (px_h),
            .px_v     (px_v),
            .slot_en  (slot_en[i]),
            .slot_x   (slot_x[i]),
            .slot_y   (slot_y[i]),
            .slot_w   (slot_w[i]),
            .slot_h   (slot_h[i]),
            .slot_base(slot_base[i]),
            .mem_we   (mem_we),
            .mem_waddr(mem_waddr),
            .mem_wdata(mem_wdata),
            .slot_hit (slot_hit[i]),
            .slot_code(slot_code[i])
        );
    end

    pixel_compositor u_compositor (
        .clk_25MHz(clk_25MHz),
        .rst      (rst),
        .px_v     (px_v),
        .slot_hit (slot_hit),
        .slot_code(slot_code),
        .pixel    (pixel)
    );

endmodule

`default_nettype wire

// ==== test/play_render_properties.sv ====
// pixel output properties of the play-field renderer, bound to the top level
`timescale 1ns/1ns
`default_nettype none

`include "render_settings.svh"

module play_render_properties (
    input logic clk_25MHz,
    input logic rst,
    input render_pkg::color_t pixel
);
    logic rst_seen = 1'b0;
    int unsigned assert_fails = 0;  // read by the testbench at the end

    always @(posedge clk_25MHz) begin
        if (rst) begin
            rst_seen <= 1'b1;
        end
    end

    a_reset_clears: assert property (@(posedge clk_25MHz) rst |=> pixel == '0)
        else begin
            assert_fails++;
            $error("pixel not cleared by reset");
        end

    a_palette: assert property (@(posedge clk_25MHz) rst_seen |-> pixel inside {
            `COLOR_SKY, `COLOR_GRASS, `COLOR_PATH, `COLOR_BOARD,
            `COLOR_WHITE, `COLOR_RED, `COLOR_BLACK})
        else begin
            assert_fails++;
            $error("pixel %h outside the palette", pixel);
        end

    a_no_x: assert property (@(posedge clk_25MHz) rst_seen |-> !$isunknown(pixel))
        else begin
            assert_fails++;
            $error("unknown bits on pixel");
        end

endmodule

bind play_render play_render_properties u_props (
    .clk_25MHz(clk_25MHz),
    .rst      (rst),
    .pixel    (pixel)
);

`default_nettype wire

// ==== test/play_render_tb.sv ====
// testbench for the play-field sprite layer, directed scans against a pixel model
`timescale 1ns/1ns
`default_nettype none

`include "render_settings.svh"

module play_render_tb;
    import render_pkg::*;
    import unit_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int SCAN_CYCLES = 40 + 18 * 18 * 5 + 26 * 18 * 2 + 34 * 34 * 2 + 18 * 18 * 6;
    localparam int RUN_CYCLES = 10 + `SPRITE_MEM_DEPTH + SCAN_CYCLES + 3 * 30;
    localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_PERIOD;
    localparam int KIND_W [4] = '{8, 12, 8, 16};
    localparam int KIND_H [4] = '{8, 8, 12, 16};
    localparam int KIND_BASE [4] = '{0, 256, 640, 1024};

    logic clk_25MHz;
    logic rst;
    coord_t h_cnt;
    coord_t v_cnt;
    unit_rec_t [`RENDER_SLOTS-1:0] unit_table;
    logic mem_we;
    sprite_addr_t mem_waddr;
    code_t mem_wdata;
    color_t pixel;

    code_t mem_copy [`SPRITE_MEM_DEPTH];  // expected sprite memory contents
    logic [31:0] rng;
    logic exp_vld_q [$];
    color_t exp_q [$];
    int exp_h_q [$];
    int exp_v_q [$];

    play_render UUT (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .h_cnt     (h_cnt),
        .v_cnt     (v_cnt),
        .unit_table(unit_table),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .pixel     (pixel)
    );

    initial begin
        clk_25MHz = 1'b0;
        forever #(CLK_PERIOD / 2) clk_25MHz = ~clk_25MHz;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic unit_rec_t make_unit(input logic exist, input int kind,
                                            input int x, input int y, input int state);
        unit_rec_t r;
        r = '0;
        r[55] = exist;
        r[54:52] = kind[2:0];
        r[51:42] = x[9:0];
        r[41:32] = y[9:0];
        r[31:20] = 12'h5a3;  // hp, ignored
        r[19:16] = state[3:0];
        r[15:0] = 16'hc3e1;  // state count and damage, ignored
        return r;
    endfunction

    function automatic color_t bg_color(input int v);
        if (v >= `BOARD_TOP) return `COLOR_BOARD;
        if (v >= `PATH_TOP && v < `PATH_END) return `COLOR_PATH;
        if (v >= `SKY_END) return `COLOR_GRASS;
        return `COLOR_SKY;
    endfunction

    // expected pixel from the current table and the loaded codes
    function automatic color_t model_pixel(input int h, input int v);
        unit_rec_t r;
        int x;
        int y;
        int w;
        int ht;
        int frame;
        code_t code;
        if (v >= `BOARD_TOP) return bg_color(v);
        for (int i = 0; i < `RENDER_SLOTS; i++) begin
            r = unit_table[i];
            x = r[51:42];
            y = r[41:32];
            if (r[55] && r[54] == 1'b0) begin
                w = KIND_W[r[53:52]];
                ht = KIND_H[r[53:52]];
                case (r[19:16])
                    4'd1: frame = r[45];  // walk steps on x bit 3
                    4'd2: frame = 2;
                    4'd3: frame = 3;
                    default: frame = 0;
                endcase
                if (h >= x && h < x + 2 * w && v >= y && v < y + 2 * ht) begin
                    code = mem_copy[KIND_BASE[r[53:52]] + frame * w * ht
                        + ((v - y) / 2) * w + (h - x) / 2];
                    case (code)
                        2'd0: return `COLOR_WHITE;
                        2'd1: return `COLOR_BLACK;
                        2'd2: return `COLOR_RED;
                        default: ;  // transparent, try lower priority
                    endcase
                end
            end
        end
        return bg_color(v);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // one cycle, checks the pixel of the coordinate driven three steps earlier
    task automatic step(input logic vld, input int h, input int v, input color_t exp);
        int ph;
        int pv;
        color_t pe;
        @(posedge clk_25MHz);
        #2;
        if (exp_q.size() == 3) begin
            ph = exp_h_q.pop_front();
            pv = exp_v_q.pop_front();
            pe = exp_q.pop_front();
            if (exp_vld_q.pop_front()) begin
                check_value($sformatf("pixel at h=%0d v=%0d", ph, pv), pixel, pe);
            end
        end
        h_cnt = h[9:0];
        v_cnt = v[9:0];
        exp_vld_q.push_back(vld);
        exp_h_q.push_back(h);
        exp_v_q.push_back(v);
        exp_q.push_back(exp);
    endtask

    task automatic scan_area(input int x0, input int y0, input int x1, input int y1,
                             input logic bg_only);
        for (int v = y0; v <= y1; v++) begin
            for (int h = x0; h <= x1; h++) begin
                step(1'b1, h, v, bg_only ? bg_color(v) : model_pixel(h, v));
            end
        end
        repeat (3) step(1'b0, 0, 0, '0);  // flush before the table changes
    endtask

    task automatic load_sprites();
        for (int a = 0; a < `SPRITE_MEM_DEPTH; a++) begin
            rng = lcg_next(rng);
            mem_copy[a] = rng[25:24];
            mem_we = 1'b1;
            mem_waddr = a[10:0];
            mem_wdata = rng[25:24];
            @(posedge clk_25MHz);
            #2;
        end
        mem_we = 1'b0;
    endtask

    task automatic reset_and_fill();
        rst = 1'b1;
        repeat (5) begin
            @(posedge clk_25MHz);
            #2;
            check_value("pixel during reset", pixel, 0);
        end
        rst = 1'b0;
        repeat (2) begin
            @(posedge clk_25MHz);
            #2;
            check_value("pixel while pipeline fills", pixel, 0);
        end
    endtask

    task automatic background_bands();
        int rows [10] = '{0, 139, 140, 169, 170, 229, 230, 269, 270, 479};
        unit_table = '0;
        foreach (rows[i]) scan_area(5, rows[i], 8, rows[i], 1'b1);
    endtask

    task automatic single_sprite();
        unit_table = '0;
        unit_table[0] = make_unit(1'b1, 0, 100, 60, 0);
        scan_area(99, 59, 116, 76, 1'b0);
    endtask

    task automatic animation_frames();
        unit_table[0] = make_unit(1'b1, 0, 96, 60, 1);   // walk, frame 0
        scan_area(95, 59, 112, 76, 1'b0);
        unit_table[0] = make_unit(1'b1, 0, 104, 60, 1);  // walk, frame 1
        scan_area(103, 59, 120, 76, 1'b0);
        unit_table[0] = make_unit(1'b1, 0, 96, 60, 2);
        scan_area(95, 59, 112, 76, 1'b0);
        unit_table[0] = make_unit(1'b1, 0, 96, 60, 3);
        scan_area(95, 59, 112, 76, 1'b0);
        unit_table[0] = make_unit(1'b1, 1, 300, 40, 1);
        scan_area(299, 39, 324, 56, 1'b0);
        unit_table[0] = make_unit(1'b1, 2, 400, 150, 2);  // spans grass and path
        scan_area(399, 149, 416, 174, 1'b0);
        unit_table[0] = make_unit(1'b1, 3, 500, 200, 3);
        scan_area(499, 199, 532, 232, 1'b0);
    endtask

    task automatic slot_priority();
        unit_table = '0;
        unit_table[2] = make_unit(1'b1, 0, 200, 100, 0);
        unit_table[5] = make_unit(1'b1, 3, 192, 92, 2);  // covers all of slot 2
        scan_area(191, 91, 224, 124, 1'b0);
    endtask

    task automatic unit_suppression();
        unit_table = '0;
        unit_table[1] = make_unit(1'b0, 0, 300, 60, 0);
        scan_area(299, 59, 316, 76, 1'b1);
        for (int k = 4; k < 8; k++) begin
            unit_table = '0;
            unit_table[k] = make_unit(1'b1, k, 300, 60, 0);
            scan_area(299, 59, 316, 76, 1'b1);
        end
        unit_table = '0;
        unit_table[6] = make_unit(1'b1, 0, 300, 270, 0);
        scan_area(299, 269, 316, 286, 1'b1);
    endtask

    initial begin
        rst = 1'b1;
        h_cnt = '0;
        v_cnt = '0;
        unit_table = '0;
        mem_we = 1'b0;
        mem_waddr = '0;
        mem_wdata = '0;
        rng = 32'h860bdba4;
        reset_and_fill();
        load_sprites();
        background_bands();
        single_sprite();
        animation_frames();
        slot_priority();
        unit_suppression();
        if (UUT.u_props.assert_fails == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("%0d pixel assertions failed during the run", UUT.u_props.assert_fails);
            $display("Checks failed");
            $fatal(1, "assertion failures");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run still going after %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
